// File: hw/cpu_mem_config.svh
`ifndef CPU_MEM_CONFIG_SVH
`define CPU_MEM_CONFIG_SVH

// datapath and address width
`define WORD_SIZE 16

// data cache geometry
`define CACHE_SETS 2
`define CACHE_WAYS 2
`define LINE_WORDS 4

// cycles a memory strobe is held per access
`define MEM_LATENCY 4

// dma target window
`define DMA_BASE_ADDR 16'h17
`define DMA_LENGTH 4'd12

`endif

// File: hw/cpu_mem_pkg.sv
`include "cpu_mem_config.svh"

package cpu_mem_pkg;

	typedef logic [`WORD_SIZE-1:0] word_t;

	// data cache controller
	typedef enum logic [1:0] {
		CACHE_IDLE,
		CACHE_FILL,
		CACHE_WRITE
	} cache_state_e;

	// current owner of the memory bus
	typedef enum logic {
		ARB_CACHE,
		ARB_DMA
	} arb_state_e;

endpackage

// File: hw/data_cache.sv
`timescale 1ns/1ps
`include "cpu_mem_config.svh"

module data_cache (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               i_read,
	input  logic               i_write,
	input  cpu_mem_pkg::word_t i_addr,
	input  cpu_mem_pkg::word_t i_wdata,
	input  logic               i_grant,
	input  cpu_mem_pkg::word_t i_mem_rdata,
	output cpu_mem_pkg::word_t o_rdata,
	output logic               o_done,
	output logic               o_hit,
	output logic               o_busy,
	output logic               o_mem_read,
	output logic               o_mem_write,
	output cpu_mem_pkg::word_t o_mem_addr,
	output cpu_mem_pkg::word_t o_mem_wdata
);
	import cpu_mem_pkg::*;

	localparam int OFF_BITS = $clog2(`LINE_WORDS);
	localparam int SET_BITS = $clog2(`CACHE_SETS);
	localparam int WAY_BITS = $clog2(`CACHE_WAYS);
	localparam int TAG_BITS = `WORD_SIZE - OFF_BITS - SET_BITS;
	localparam int LAT_BITS = $clog2(`MEM_LATENCY);

	cache_state_e state;

	logic [OFF_BITS-1:0] offset;
	logic [SET_BITS-1:0] set_idx;
	logic [TAG_BITS-1:0] tag;

	// per-way line storage
	logic [`CACHE_WAYS-1:0][`CACHE_SETS-1:0] valid;
	logic [TAG_BITS-1:0] tag_mem [`CACHE_WAYS][`CACHE_SETS];
	word_t data_mem [`CACHE_WAYS][`CACHE_SETS][`LINE_WORDS];

	// one bit per set, names the way to evict next
	logic [`CACHE_SETS-1:0] lru;

	logic                hit;
	logic [WAY_BITS-1:0] hit_way;
	logic [WAY_BITS-1:0] victim;
	logic [LAT_BITS-1:0] lat_cnt;
	logic [OFF_BITS-1:0] fill_word;
	logic                lat_done;
	logic                line_done;
	logic                accept;

	assign offset  = i_addr[OFF_BITS-1:0];
	assign set_idx = i_addr[OFF_BITS +: SET_BITS];
	assign tag     = i_addr[`WORD_SIZE-1 -: TAG_BITS];

	always_comb begin
		hit = 1'b0;
		hit_way = '0;
		for (int w = 0; w < `CACHE_WAYS; w++) begin
			if (valid[w][set_idx] && tag_mem[w][set_idx] == tag) begin
				hit = 1'b1;
				hit_way = WAY_BITS'(w);
			end
		end
	end

	assign victim = lru[set_idx];

	// last granted cycle of one strobe run
	assign lat_done  = i_grant && (lat_cnt == LAT_BITS'(`MEM_LATENCY - 1));
	assign line_done = fill_word == OFF_BITS'(`LINE_WORDS - 1);

	// skip the o_done cycle, the request level is still up then
	assign accept = (state == CACHE_IDLE) && !o_done;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= CACHE_IDLE;
			lat_cnt <= '0;
			fill_word <= '0;
			valid <= '0;
			lru <= '0;
			o_done <= 1'b0;
			o_hit <= 1'b0;
		end else begin
			o_done <= 1'b0;
			o_hit <= 1'b0;
			case (state)
				CACHE_IDLE: begin
					lat_cnt <= '0;
					fill_word <= '0;
					if (accept && i_read) begin
						if (hit) begin
							o_done <= 1'b1;
							o_hit <= 1'b1;
							lru[set_idx] <= ~hit_way;
						end else begin
							state <= CACHE_FILL;
						end
					end else if (accept && i_write) begin
						state <= CACHE_WRITE;
					end
				end
				CACHE_FILL: begin
					if (i_grant) begin
						lat_cnt <= lat_done ? '0 : lat_cnt + 1'b1;
					end
					if (lat_done) begin
						fill_word <= fill_word + 1'b1;
						if (line_done) begin
							valid[victim][set_idx] <= 1'b1;
							lru[set_idx] <= ~victim;
							o_done <= 1'b1;
							state <= CACHE_IDLE;
						end
					end
				end
				CACHE_WRITE: begin
					if (i_grant) begin
						lat_cnt <= lat_done ? '0 : lat_cnt + 1'b1;
					end
					if (lat_done) begin
						if (hit) begin
							lru[set_idx] <= ~hit_way;
						end
						o_hit <= hit;
						o_done <= 1'b1;
						state <= CACHE_IDLE;
					end
				end
				default: state <= CACHE_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept && i_read && hit) begin
			o_rdata <= data_mem[hit_way][set_idx][offset];
		end
		if (state == CACHE_FILL && lat_done) begin
			data_mem[victim][set_idx][fill_word] <= i_mem_rdata;
			// requested word goes straight to the cpu
			if (fill_word == offset) begin
				o_rdata <= i_mem_rdata;
			end
			if (line_done) begin
				tag_mem[victim][set_idx] <= tag;
			end
		end
		// write hit updates the line, write miss leaves it alone
		if (state == CACHE_WRITE && lat_done && hit) begin
			data_mem[hit_way][set_idx][offset] <= i_wdata;
		end
	end

	assign o_busy      = state != CACHE_IDLE;
	assign o_mem_read  = (state == CACHE_FILL) && i_grant;
	assign o_mem_write = (state == CACHE_WRITE) && i_grant;
	assign o_mem_addr  = (state == CACHE_FILL) ?
		{i_addr[`WORD_SIZE-1:OFF_BITS], fill_word} : i_addr;
	assign o_mem_wdata = i_wdata;

	a_one_request: assert property (@(posedge clk) disable iff (!reset_n)
		!(i_read && i_write));

	a_one_strobe: assert property (@(posedge clk) disable iff (!reset_n)
		!(o_mem_read && o_mem_write));

	a_strobe_granted: assert property (@(posedge clk) disable iff (!reset_n)
		(o_busy && !i_grant) |=> $stable(lat_cnt) && $stable(fill_word));

endmodule

// File: hw/dma_channel.sv
`timescale 1ns/1ps
`include "cpu_mem_config.svh"

module dma_channel (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               i_external_interrupt,
	input  logic               i_dma_interrupt,
	input  logic               i_dma_bg,
	output logic               o_dma_start,
	output logic [3:0]         o_dma_length,
	output cpu_mem_pkg::word_t o_dma_addr
);

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			o_dma_start <= 1'b0;
			o_dma_length <= '0;
		end else begin
			// done interrupt wins over a new request
			if (i_dma_interrupt) begin
				o_dma_start <= 1'b0;
			end else if (i_external_interrupt) begin
				o_dma_start <= 1'b1;
			end
			if (i_external_interrupt) begin
				o_dma_length <= `DMA_LENGTH;
			end
		end
	end

	// one word per granted cycle
	always_ff @(posedge clk) begin
		if (!reset_n) begin
			o_dma_addr <= `DMA_BASE_ADDR;
		end else if (i_external_interrupt) begin
			o_dma_addr <= `DMA_BASE_ADDR;
		end else if (i_dma_bg) begin
			o_dma_addr <= o_dma_addr + 1'b1;
		end
	end

	a_addr_in_window: assert property (@(posedge clk) disable iff (!reset_n)
		o_dma_start |-> (o_dma_addr >= `DMA_BASE_ADDR) &&
			(o_dma_addr <= `DMA_BASE_ADDR + `DMA_LENGTH));

endmodule

// File: hw/bus_arbiter.sv
`timescale 1ns/1ps
`include "cpu_mem_config.svh"

module bus_arbiter (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               i_dma_br,
	input  logic               i_cache_busy,
	input  cpu_mem_pkg::word_t i_dma_addr,
	input  cpu_mem_pkg::word_t i_dma_wdata,
	input  logic               i_cache_read,
	input  logic               i_cache_write,
	input  cpu_mem_pkg::word_t i_cache_addr,
	input  cpu_mem_pkg::word_t i_cache_wdata,
	output logic               o_dma_bg,
	output logic               o_cache_grant,
	output logic               o_mem_read,
	output logic               o_mem_write,
	output cpu_mem_pkg::word_t o_mem_addr,
	output cpu_mem_pkg::word_t o_mem_wdata
);
	import cpu_mem_pkg::*;

	arb_state_e state;

	always_ff @(posedge clk) begin
		if (!reset_n) begin
			state <= ARB_CACHE;
		end else begin
			case (state)
				ARB_CACHE: begin
					// wait for the cache to finish its access
					if (i_dma_br && !i_cache_busy) begin
						state <= ARB_DMA;
					end
				end
				ARB_DMA: begin
					if (!i_dma_br) begin
						state <= ARB_CACHE;
					end
				end
				default: state <= ARB_CACHE;
			endcase
		end
	end

	assign o_dma_bg      = state == ARB_DMA;
	assign o_cache_grant = state == ARB_CACHE;

	// dma owns the bus as a write every granted cycle
	assign o_mem_read  = o_dma_bg ? 1'b0 : i_cache_read;
	assign o_mem_write = o_dma_bg ? 1'b1 : i_cache_write;
	assign o_mem_addr  = o_dma_bg ? i_dma_addr : i_cache_addr;
	assign o_mem_wdata = o_dma_bg ? i_dma_wdata : i_cache_wdata;

	a_no_grant_busy: assert property (@(posedge clk) disable iff (!reset_n)
		o_dma_bg |-> !(i_cache_read || i_cache_write));

endmodule

// File: hw/mem_subsystem_top.sv
`timescale 1ns/1ps
`include "cpu_mem_config.svh"

module mem_subsystem_top (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               i_read,
	input  logic               i_write,
	input  cpu_mem_pkg::word_t i_addr,
	input  cpu_mem_pkg::word_t i_wdata,
	output cpu_mem_pkg::word_t o_rdata,
	output logic               o_done,
	output logic               o_hit,
	input  logic               i_external_interrupt,
	input  logic               i_dma_interrupt,
	input  logic               i_dma_br,
	input  cpu_mem_pkg::word_t i_dma_wdata,
	output logic               o_dma_bg,
	output logic               o_dma_start,
	output logic [3:0]         o_dma_length,
	output logic               o_mem_read,
	output logic               o_mem_write,
	output cpu_mem_pkg::word_t o_mem_addr,
	output cpu_mem_pkg::word_t o_mem_wdata,
	input  cpu_mem_pkg::word_t i_mem_rdata
);
	import cpu_mem_pkg::*;

	logic  c_mem_read;
	logic  c_mem_write;
	word_t c_mem_addr;
	word_t c_mem_wdata;
	logic  c_busy;
	logic  c_grant;
	word_t dma_addr;

	data_cache u_data_cache (
		.clk         (clk),
		.reset_n     (reset_n),
		.i_read      (i_read),
		.i_write     (i_write),
		.i_addr      (i_addr),
		.i_wdata     (i_wdata),
		.i_grant     (c_grant),
		.i_mem_rdata (i_mem_rdata),
		.o_rdata     (o_rdata),
		.o_done      (o_done),
		.o_hit       (o_hit),
		.o_busy      (c_busy),
		.o_mem_read  (c_mem_read),
		.o_mem_write (c_mem_write),
		.o_mem_addr  (c_mem_addr),
		.o_mem_wdata (c_mem_wdata)
	);

	dma_channel u_dma_channel (
		.clk                  (clk),
		.reset_n              (reset_n),
		.i_external_interrupt (i_external_interrupt),
		.i_dma_interrupt      (i_dma_interrupt),
		.i_dma_bg             (o_dma_bg),
		.o_dma_start          (o_dma_start),
		.o_dma_length         (o_dma_length),
		.o_dma_addr           (dma_addr)
	);

	bus_arbiter u_bus_arbiter (
		.clk           (clk),
		.reset_n       (reset_n),
		.i_dma_br      (i_dma_br),
		.i_cache_busy  (c_busy),
		.i_dma_addr    (dma_addr),
		.i_dma_wdata   (i_dma_wdata),
		.i_cache_read  (c_mem_read),
		.i_cache_write (c_mem_write),
		.i_cache_addr  (c_mem_addr),
		.i_cache_wdata (c_mem_wdata),
		.o_dma_bg      (o_dma_bg),
		.o_cache_grant (c_grant),
		.o_mem_read    (o_mem_read),
		.o_mem_write   (o_mem_write),
		.o_mem_addr    (o_mem_addr),
		.o_mem_wdata   (o_mem_wdata)
	);

endmodule

// File: verif/tb_mem_subsystem.sv
`timescale 1ns/1ps
`include "cpu_mem_config.svh"

module tb_mem_subsystem;
	import cpu_mem_pkg::*;

	localparam int TIMEOUT = 2000;
	localparam int DMA_WORDS = 12;

	logic clk = 1'b0;
	logic reset_n, i_read, i_write, o_done, o_hit;
	logic i_external_interrupt, i_dma_interrupt, i_dma_br, o_dma_bg, o_dma_start;
	logic o_mem_read, o_mem_write;
	logic [3:0] o_dma_length;
	word_t i_addr, i_wdata, o_rdata, i_dma_wdata;
	word_t o_mem_addr, o_mem_wdata, i_mem_rdata;

	word_t mem [64];
	// expected memory contents
	word_t sb [64];
	int wr_run = 0;
	int rd_strobes = 0;
	int strobes_before;
	int cycles = 0;
	int errors = 0;
	int errors_at_start, passed = 0, failed = 0;
	int grant_cnt, done_cnt;
	integer seed = 32'h1e85;
	string test_name;
	word_t rd_data, wval;
	logic rd_hit;

	mem_subsystem_top DUT (.*);

	always #2 clk = ~clk;

	assign i_mem_rdata = mem[o_mem_addr[5:0]];

	// dma writes every granted cycle, cache writes at the end of a strobe run
	always @(posedge clk) begin
		if (!reset_n) begin
			wr_run <= 0;
		end else if (o_dma_bg) begin
			mem[o_mem_addr[5:0]] <= o_mem_wdata;
		end else if (o_mem_write) begin
			if (wr_run == `MEM_LATENCY - 1) begin
				mem[o_mem_addr[5:0]] <= o_mem_wdata;
				wr_run <= 0;
			end else begin
				wr_run <= wr_run + 1;
			end
		end
	end

	// read strobe cycles seen on the bus
	always @(posedge clk) begin
		if (o_mem_read) begin
			rd_strobes <= rd_strobes + 1;
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT) begin
			$display("timeout: run did not finish within %0d cycles", TIMEOUT);
			$display("TEST FAIL");
			$finish;
		end
	end

	task automatic start_test(input string name);
		test_name = name;
		errors_at_start = errors;
	endtask

	task automatic finish_test();
		if (errors == errors_at_start) begin
			passed++;
			$display("[%s] ok", test_name);
		end else begin
			failed++;
			$display("[%s] failed with %0d error(s)", test_name, errors - errors_at_start);
		end
	endtask

	task automatic check_value(input string what, input word_t exp, input word_t act);
		assert (act === exp) else begin
			$display("FAIL %s %s expected %h actual %h", test_name, what, exp, act);
			errors++;
		end
	endtask

	task automatic cpu_read(input word_t addr, output word_t data, output logic hit);
		i_addr <= addr;
		i_read <= 1'b1;
		@(posedge clk);
		while (!o_done) begin
			@(posedge clk);
		end
		data = o_rdata;
		hit = o_hit;
		i_read <= 1'b0;
	endtask

	task automatic cpu_write(input word_t addr, input word_t data);
		i_addr <= addr;
		i_wdata <= data;
		i_write <= 1'b1;
		sb[addr[5:0]] = data;
		@(posedge clk);
		while (!o_done) begin
			@(posedge clk);
		end
		i_write <= 1'b0;
	endtask

	initial begin
		reset_n = 1'b0;
		i_read = 1'b0;
		i_write = 1'b0;
		i_addr = '0;
		i_wdata = '0;
		i_external_interrupt = 1'b0;
		i_dma_interrupt = 1'b0;
		i_dma_br = 1'b0;
		i_dma_wdata = '0;
		for (int i = 0; i < 64; i++) begin
			mem[i] = $random(seed);
			sb[i] = mem[i];
		end
		repeat (10) @(posedge clk);
		reset_n <= 1'b1;
		@(posedge clk);

		start_test("read_miss_then_hit");
		strobes_before = rd_strobes;
		cpu_read(16'h04, rd_data, rd_hit);
		check_value("miss data", sb[4], rd_data);
		check_value("miss flag", 16'd0, rd_hit);
		check_value("fill strobes", `LINE_WORDS * `MEM_LATENCY, rd_strobes - strobes_before);
		strobes_before = rd_strobes;
		cpu_read(16'h05, rd_data, rd_hit);
		check_value("hit data", sb[5], rd_data);
		check_value("hit flag", 16'd1, rd_hit);
		check_value("hit strobes", 16'd0, rd_strobes - strobes_before);
		finish_test();

		start_test("write_through");
		wval = $random(seed);
		cpu_write(16'h06, wval);
		check_value("memory", sb[6], mem[6]);
		cpu_read(16'h06, rd_data, rd_hit);
		check_value("read back", sb[6], rd_data);
		finish_test();

		// three tags in set 0 evict the first one
		start_test("lru_replace");
		cpu_read(16'h08, rd_data, rd_hit);
		check_value("tag 1 data", sb[8], rd_data);
		cpu_read(16'h28, rd_data, rd_hit);
		check_value("tag 5 data", sb[40], rd_data);
		cpu_read(16'h30, rd_data, rd_hit);
		check_value("tag 6 data", sb[48], rd_data);
		cpu_read(16'h08, rd_data, rd_hit);
		check_value("evicted data", sb[8], rd_data);
		check_value("evicted flag", 16'd0, rd_hit);
		finish_test();

		start_test("dma_interrupts");
		i_external_interrupt <= 1'b1;
		@(posedge clk);
		i_external_interrupt <= 1'b0;
		@(posedge clk);
		check_value("start set", 16'd1, o_dma_start);
		check_value("length", 16'd12, o_dma_length);
		i_dma_interrupt <= 1'b1;
		@(posedge clk);
		i_dma_interrupt <= 1'b0;
		@(posedge clk);
		check_value("start cleared", 16'd0, o_dma_start);
		finish_test();

		start_test("dma_transfer");
		grant_cnt = 0;
		// start the channel so the transfer runs with o_dma_start high
		i_external_interrupt <= 1'b1;
		@(posedge clk);
		i_external_interrupt <= 1'b0;
		fork
			begin
				i_dma_br <= 1'b1;
				for (int k = 0; k < DMA_WORDS; k++) begin
					@(posedge clk);
					if (o_dma_bg) grant_cnt++;
					// grant starts the cycle after the request
					wval = $random(seed);
					i_dma_wdata <= wval;
					sb[(`DMA_BASE_ADDR + k) % 64] = wval;
					if (k == DMA_WORDS - 1) i_dma_br <= 1'b0;
				end
				repeat (3) begin
					@(posedge clk);
					if (o_dma_bg) grant_cnt++;
				end
			end
			begin
				repeat (3) @(posedge clk);
				cpu_read(`DMA_BASE_ADDR + 5, rd_data, rd_hit);
				done_cnt = grant_cnt;
			end
		join
		i_dma_interrupt <= 1'b1;
		@(posedge clk);
		i_dma_interrupt <= 1'b0;
		check_value("granted cycles", 16'd12, grant_cnt);
		check_value("grants before done", 16'd12, done_cnt);
		check_value("read data", sb[`DMA_BASE_ADDR + 5], rd_data);
		for (int k = 0; k < DMA_WORDS; k++) begin
			check_value("dma word", sb[`DMA_BASE_ADDR + k], mem[`DMA_BASE_ADDR + k]);
		end
		finish_test();

		$display("%0d tests, %0d passed, %0d failed, %0d check errors",
			passed + failed, passed, failed, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

// File: build.f
+incdir+hw
hw/cpu_mem_pkg.sv
hw/data_cache.sv
hw/dma_channel.sv
hw/bus_arbiter.sv
hw/mem_subsystem_top.sv
verif/tb_mem_subsystem.sv

// File: Bender.yml
package:
  name: cpu_mem_subsystem

sources:
  - include_dirs:
      - hw
    files:
      - hw/cpu_mem_pkg.sv
      - hw/data_cache.sv
      - hw/dma_channel.sv
      - hw/bus_arbiter.sv
      - hw/mem_subsystem_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/tb_mem_subsystem.sv
